//--- verilog/trdb_cfg.svh
// ******************************
// build-time sizes of the trace encoder
// include wherever the widths are needed
// ******************************

`ifndef TRDB_CFG_SVH
`define TRDB_CFG_SVH

// address and instruction word width
// one word on rv32 cores
`define TRDB_XLEN 32

// branch map depth
// a full map forces a branch-only packet
// must stay below 32 so the count fits in 5 bits
`define TRDB_BRANCH_MAP_LEN 31

`endif

//--- verilog/trdb_pkg.sv
// ******************************
// shared types and opcode constants of the trace encoder
// ******************************

`include "trdb_cfg.svh"

package trdb_pkg;

    // widths with a meaning
    typedef logic [`TRDB_XLEN-1:0] trdb_addr_t;
    typedef logic [`TRDB_XLEN-1:0] trdb_insn_t;
    typedef logic [$clog2(`TRDB_BRANCH_MAP_LEN + 1)-1:0] trdb_bcount_t;
    // bit i holds the outcome of the i-th branch to arrive
    typedef logic [`TRDB_BRANCH_MAP_LEN-1:0] trdb_bmap_t;

    // one retired instruction as reported by the core
    typedef struct packed {
        trdb_addr_t iaddr;
        trdb_insn_t insn;
        logic       compressed;
        logic       exception;
    } trdb_retire_t;

    // packet formats, loosely after the e-trace numbering
    typedef enum logic [1:0] {
        FMT_BRANCH = 2'd1,
        FMT_ADDR   = 2'd2,
        FMT_SYNC   = 2'd3
    } trdb_format_e;

    // address is full for sync, a delta for addr, zero for branch
    typedef struct packed {
        trdb_format_e format;
        trdb_bcount_t branch_count;
        trdb_bmap_t   branch_map;
        trdb_addr_t   address;
    } trdb_packet_t;

    typedef enum logic {
        IDLE,
        RUN
    } trdb_emit_state_e;

    // conditional branches, rv32i
    localparam trdb_insn_t MASK_BEQ        = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BEQ       = 32'h0000_0063;
    localparam trdb_insn_t MASK_BNE        = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BNE       = 32'h0000_1063;
    localparam trdb_insn_t MASK_BLT        = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BLT       = 32'h0000_4063;
    localparam trdb_insn_t MASK_BGE        = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BGE       = 32'h0000_5063;
    localparam trdb_insn_t MASK_BLTU       = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BLTU      = 32'h0000_6063;
    localparam trdb_insn_t MASK_BGEU       = 32'h0000_707f;
    localparam trdb_insn_t MATCH_BGEU      = 32'h0000_7063;
    // pulp immediate-compare branches
    localparam trdb_insn_t MASK_P_BEQIMM   = 32'h0000_707f;
    localparam trdb_insn_t MATCH_P_BEQIMM  = 32'h0000_2063;
    localparam trdb_insn_t MASK_P_BNEIMM   = 32'h0000_707f;
    localparam trdb_insn_t MATCH_P_BNEIMM  = 32'h0000_3063;
    // compressed branches live in the low half
    localparam trdb_insn_t MASK_C_BEQZ     = 32'h0000_e003;
    localparam trdb_insn_t MATCH_C_BEQZ    = 32'h0000_c001;
    localparam trdb_insn_t MASK_C_BNEZ     = 32'h0000_e003;
    localparam trdb_insn_t MATCH_C_BNEZ    = 32'h0000_e001;
    // indirect jump
    localparam trdb_insn_t MASK_JALR       = 32'h0000_707f;
    localparam trdb_insn_t MATCH_JALR      = 32'h0000_0067;

endpackage

//--- verilog/trdb_retire_pipe.sv
// ******************************
// two-deep store of retired records
// presents the tc/nc pair with a one-cycle strobe
// ******************************

`timescale 1ns/1ps

module trdb_retire_pipe (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  retire_valid_i,
    input  trdb_pkg::trdb_retire_t retire_i,
    output trdb_pkg::trdb_retire_t tc_o,
    output trdb_pkg::trdb_retire_t nc_o,
    output logic                  pair_valid_o
);

    import trdb_pkg::*;

    // set once the first record is in
    logic         fill_q;
    logic         pair_valid_q;
    trdb_retire_t tc_q;
    trdb_retire_t nc_q;

    // control state
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_q       <= 1'b0;
            pair_valid_q <= 1'b0;
        end else begin
            // a pair exists only when an older record was already held
            pair_valid_q <= retire_valid_i && fill_q;
            if (retire_valid_i) begin
                fill_q <= 1'b1;
            end
        end
    end

    // record payload
    always_ff @(posedge clk_i) begin
        if (retire_valid_i) begin
            // nc ages into tc
            tc_q <= nc_q;
            nc_q <= retire_i;
        end
    end

    assign tc_o         = tc_q;
    assign nc_o         = nc_q;
    assign pair_valid_o = pair_valid_q;

endmodule

//--- verilog/trdb_itype_detector.sv
// ******************************
// classifies the tc/nc pair for the emitter
// purely combinational, read only while the pair is valid
// ******************************

`timescale 1ns/1ps

module trdb_itype_detector (
    input  trdb_pkg::trdb_retire_t tc_i,
    input  trdb_pkg::trdb_retire_t nc_i,
    output logic                  nc_branch_o,
    output logic                  tc_branch_taken_o,
    output logic                  nc_updiscon_o
);

    import trdb_pkg::*;

    // fall-through address of tc
    trdb_addr_t tc_seq_addr;
    logic       nc_is_jalr;
    logic       nc_is_rv_branch;
    logic       nc_is_pulp_branch;
    logic       nc_is_c_branch;

    // base isa conditional branches
    assign nc_is_rv_branch =
        ((nc_i.insn & MASK_BEQ)  == MATCH_BEQ)  ||
        ((nc_i.insn & MASK_BNE)  == MATCH_BNE)  ||
        ((nc_i.insn & MASK_BLT)  == MATCH_BLT)  ||
        ((nc_i.insn & MASK_BGE)  == MATCH_BGE)  ||
        ((nc_i.insn & MASK_BLTU) == MATCH_BLTU) ||
        ((nc_i.insn & MASK_BGEU) == MATCH_BGEU);

    // pulp extension
    assign nc_is_pulp_branch =
        ((nc_i.insn & MASK_P_BEQIMM) == MATCH_P_BEQIMM) ||
        ((nc_i.insn & MASK_P_BNEIMM) == MATCH_P_BNEIMM);

    // c.beqz / c.bnez
    assign nc_is_c_branch =
        ((nc_i.insn & MASK_C_BEQZ) == MATCH_C_BEQZ) ||
        ((nc_i.insn & MASK_C_BNEZ) == MATCH_C_BNEZ);

    assign nc_branch_o = nc_is_rv_branch || nc_is_pulp_branch || nc_is_c_branch;

    // half-word step for compressed code
    assign tc_seq_addr = tc_i.iaddr + (tc_i.compressed ? trdb_addr_t'(2) : trdb_addr_t'(4));

    // taken when nc is not the fall-through
    assign tc_branch_taken_o = (nc_i.iaddr != tc_seq_addr);

    // target of jalr cannot be inferred from the binary
    assign nc_is_jalr    = ((nc_i.insn & MASK_JALR) == MATCH_JALR);
    assign nc_updiscon_o = nc_is_jalr || nc_i.exception;

endmodule

//--- verilog/trdb_addr_tracker.sv
// ******************************
// last reported address and the delta of nc from it
// loaded whenever the emitter sends an address
// ******************************

`timescale 1ns/1ps

module trdb_addr_tracker (
    input  logic                clk_i,
    input  logic                arst_n_i,
    input  trdb_pkg::trdb_addr_t nc_iaddr_i,
    input  logic                addr_sent_i,
    input  trdb_pkg::trdb_addr_t report_addr_i,
    output trdb_pkg::trdb_addr_t addr_diff_o
);

    import trdb_pkg::*;

    // address carried by the newest sync or addr packet
    trdb_addr_t last_addr_q;

    // loads on the same edge the packet is registered
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            last_addr_q <= '0;
        end else if (addr_sent_i) begin
            last_addr_q <= report_addr_i;
        end
    end

    // wraps modulo 2^xlen, decoder adds it back the same way
    assign addr_diff_o = nc_iaddr_i - last_addr_q;

endmodule

//--- verilog/trdb_packet_emitter.sv
// ******************************
// branch map accumulation and packet generation
// one sync after reset, then addr and branch packets per pair
// ******************************

`timescale 1ns/1ps

`include "trdb_cfg.svh"

module trdb_packet_emitter (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  pair_valid_i,
    input  trdb_pkg::trdb_addr_t   tc_iaddr_i,
    input  trdb_pkg::trdb_addr_t   nc_iaddr_i,
    input  logic                  nc_branch_i,
    input  logic                  tc_branch_taken_i,
    input  logic                  nc_updiscon_i,
    input  trdb_pkg::trdb_addr_t   addr_diff_i,
    output logic                  addr_sent_o,
    output trdb_pkg::trdb_addr_t   report_addr_o,
    output logic                  packet_valid_o,
    output trdb_pkg::trdb_packet_t packet_o
);

    import trdb_pkg::*;

    trdb_emit_state_e state_q;
    trdb_emit_state_e state_d;
    // detector flags of the previous nc, now describing tc
    logic             tc_is_branch_q;
    logic             tc_updiscon_q;
    trdb_bmap_t       bmap_q;
    trdb_bmap_t       bmap_d;
    trdb_bcount_t     bcount_q;
    trdb_bcount_t     bcount_d;
    // map after appending the tc outcome
    trdb_bmap_t       bmap_upd;
    trdb_bcount_t     bcount_upd;
    logic             emit;
    trdb_packet_t     packet_d;
    logic             packet_valid_q;
    trdb_packet_t     packet_q;

    // append tc outcome at the current fill level
    always_comb begin
        bmap_upd   = bmap_q;
        bcount_upd = bcount_q;
        if (tc_is_branch_q) begin
            bmap_upd[bcount_q] = tc_branch_taken_i;
            bcount_upd         = bcount_q + trdb_bcount_t'(1);
        end
    end

    // emission rules, sync first, then updiscon over full map
    always_comb begin
        state_d  = state_q;
        bmap_d   = bmap_q;
        bcount_d = bcount_q;
        emit     = 1'b0;
        packet_d = '0;
        if (pair_valid_i) begin
            if (state_q == IDLE) begin
                // full address of the oldest instruction
                emit             = 1'b1;
                packet_d.format  = FMT_SYNC;
                packet_d.address = tc_iaddr_i;
                bmap_d           = '0;
                bcount_d         = '0;
                state_d          = RUN;
            end else if (tc_updiscon_q) begin
                // delta to the jump target plus the partial map
                emit                  = 1'b1;
                packet_d.format       = FMT_ADDR;
                packet_d.branch_count = bcount_upd;
                packet_d.branch_map   = bmap_upd;
                packet_d.address      = addr_diff_i;
                bmap_d                = '0;
                bcount_d              = '0;
            end else if (bcount_upd == trdb_bcount_t'(`TRDB_BRANCH_MAP_LEN)) begin
                // map full, flush without address
                emit                  = 1'b1;
                packet_d.format       = FMT_BRANCH;
                packet_d.branch_count = bcount_upd;
                packet_d.branch_map   = bmap_upd;
                bmap_d                = '0;
                bcount_d              = '0;
            end else begin
                bmap_d   = bmap_upd;
                bcount_d = bcount_upd;
            end
        end
    end

    // state, flags and map
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q        <= IDLE;
            tc_is_branch_q <= 1'b0;
            tc_updiscon_q  <= 1'b0;
            bmap_q         <= '0;
            bcount_q       <= '0;
            packet_valid_q <= 1'b0;
        end else begin
            packet_valid_q <= emit;
            if (pair_valid_i) begin
                state_q        <= state_d;
                tc_is_branch_q <= nc_branch_i;
                tc_updiscon_q  <= nc_updiscon_i;
                bmap_q         <= bmap_d;
                bcount_q       <= bcount_d;
            end
        end
    end

    // packet payload
    always_ff @(posedge clk_i) begin
        if (emit) begin
            packet_q <= packet_d;
        end
    end

    // tracker reloads whenever an address goes out
    assign addr_sent_o   = emit && (packet_d.format != FMT_BRANCH);
    // sync reports tc, addr reports the jump target in nc
    assign report_addr_o = (state_q == IDLE) ? tc_iaddr_i : nc_iaddr_i;

    assign packet_valid_o = packet_valid_q;
    assign packet_o       = packet_q;

endmodule

//--- verilog/trdb_encoder.sv
// ******************************
// trace encoder top level
// retire strobe in, one packet per emission out
// ******************************

`timescale 1ns/1ps

module trdb_encoder (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  retire_valid_i,
    input  trdb_pkg::trdb_retire_t retire_i,
    output logic                  packet_valid_o,
    output trdb_pkg::trdb_packet_t packet_o
);

    import trdb_pkg::*;

    // current and next instruction
    trdb_retire_t tc;
    trdb_retire_t nc;
    logic         pair_valid;
    // detector flags
    logic         nc_branch;
    logic         tc_branch_taken;
    logic         nc_updiscon;
    // address feedback loop
    trdb_addr_t   addr_diff;
    logic         addr_sent;
    trdb_addr_t   report_addr;

    trdb_retire_pipe i_retire_pipe (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .retire_valid_i (retire_valid_i),
        .retire_i       (retire_i),
        .tc_o           (tc),
        .nc_o           (nc),
        .pair_valid_o   (pair_valid)
    );

    trdb_itype_detector i_itype_detector (
        .tc_i              (tc),
        .nc_i              (nc),
        .nc_branch_o       (nc_branch),
        .tc_branch_taken_o (tc_branch_taken),
        .nc_updiscon_o     (nc_updiscon)
    );

    trdb_addr_tracker i_addr_tracker (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .nc_iaddr_i    (nc.iaddr),
        .addr_sent_i   (addr_sent),
        .report_addr_i (report_addr),
        .addr_diff_o   (addr_diff)
    );

    trdb_packet_emitter i_packet_emitter (
        .clk_i             (clk_i),
        .arst_n_i          (arst_n_i),
        .pair_valid_i      (pair_valid),
        .tc_iaddr_i        (tc.iaddr),
        .nc_iaddr_i        (nc.iaddr),
        .nc_branch_i       (nc_branch),
        .tc_branch_taken_i (tc_branch_taken),
        .nc_updiscon_i     (nc_updiscon),
        .addr_diff_i       (addr_diff),
        .addr_sent_o       (addr_sent),
        .report_addr_o     (report_addr),
        .packet_valid_o    (packet_valid_o),
        .packet_o          (packet_o)
    );

endmodule

//--- tests/trdb_encoder_properties.sv
// ******************************
// concurrent checks on the encoder outputs
// bound into every trdb_encoder instance
// ******************************

`timescale 1ns/1ps

`include "trdb_cfg.svh"

module trdb_encoder_properties (
    input logic                   clk_i,
    input logic                   arst_n_i,
    input logic                   pair_valid,
    input logic                   packet_valid_o,
    input trdb_pkg::trdb_packet_t packet_o
);

    import trdb_pkg::*;

    // no packets while reset is held
    quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !packet_valid_o)
        else $error("packet_valid_o high during reset");

    // each pulse belongs to exactly one pair cycle before it
    pulse_per_pair: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        packet_valid_o |-> $past(pair_valid))
        else $error("packet_valid_o without a pair in the cycle before");

    // no taken bits recorded beyond the count
    map_within_count: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        packet_valid_o |-> (packet_o.branch_map >> packet_o.branch_count) == '0)
        else $error("branch_map bits set beyond branch_count");

    // branch-only packets go out only on a full map
    branch_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        packet_valid_o && packet_o.format == FMT_BRANCH
        |-> packet_o.branch_count == trdb_bcount_t'(`TRDB_BRANCH_MAP_LEN))
        else $error("branch packet with a partial map");

endmodule

bind trdb_encoder trdb_encoder_properties i_properties (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .pair_valid     (pair_valid),
    .packet_valid_o (packet_valid_o),
    .packet_o       (packet_o)
);

//--- tests/tb_trdb_encoder.sv
// ******************************
// testbench of the trace encoder, seeded random programs
// checked packet by packet against a reference model
// ******************************

`timescale 1ns/1ps

`include "trdb_cfg.svh"

module tb_trdb_encoder;

    import trdb_pkg::*;

    logic         clk_i;
    logic         arst_n_i;
    logic         retire_valid_i;
    trdb_retire_t retire_i;
    logic         packet_valid_o;
    trdb_packet_t packet_o;

    // retired stream, expected and received packets
    trdb_retire_t stim_q[$];
    trdb_packet_t exp_q[$];
    trdb_packet_t got_q[$];
    trdb_packet_t ref_q[$];
    trdb_addr_t   pc;
    int           cyc = 0;
    int           sync_cyc = 0;
    int           err_cnt = 0;
    int           check_cnt = 0;
    int           test_cnt = 0;
    int           fail_tests = 0;
    logic         first_seen;

    trdb_encoder UUT (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .retire_valid_i (retire_valid_i),
        .retire_i       (retire_i),
        .packet_valid_o (packet_valid_o),
        .packet_o       (packet_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    // all ten conditional branch encodings
    function automatic logic is_branch(input trdb_insn_t w);
        return ((w & MASK_BEQ) == MATCH_BEQ) || ((w & MASK_BNE) == MATCH_BNE) ||
               ((w & MASK_BLT) == MATCH_BLT) || ((w & MASK_BGE) == MATCH_BGE) ||
               ((w & MASK_BLTU) == MATCH_BLTU) || ((w & MASK_BGEU) == MATCH_BGEU) ||
               ((w & MASK_P_BEQIMM) == MATCH_P_BEQIMM) ||
               ((w & MASK_P_BNEIMM) == MATCH_P_BNEIMM) ||
               ((w & MASK_C_BEQZ) == MATCH_C_BEQZ) || ((w & MASK_C_BNEZ) == MATCH_C_BNEZ);
    endfunction

    // sample packets mid-cycle, compare with the queue head
    always @(negedge clk_i) begin
        trdb_packet_t exp;
        if (arst_n_i && packet_valid_o) begin
            if (!first_seen) begin
                first_seen = 1'b1;
                check_field("packet_valid_o cycle", 32'(cyc), 32'(sync_cyc));
            end
            got_q.push_back(packet_o);
            assert (exp_q.size() != 0) else begin
                $display("a packet arrived at %0t although none was expected", $time);
                err_cnt++;
            end
            if (exp_q.size() != 0) begin
                exp = exp_q.pop_front();
                check_field("packet_o.format", 32'(packet_o.format), 32'(exp.format));
                check_field("packet_o.branch_count", 32'(packet_o.branch_count),
                            32'(exp.branch_count));
                check_field("packet_o.branch_map", 32'(packet_o.branch_map),
                            32'(exp.branch_map));
                check_field("packet_o.address", packet_o.address, exp.address);
            end
        end
    end

    // plain alu op, 2 or 4 bytes
    task automatic straight_line(input logic c);
        trdb_retire_t r;
        r.iaddr      = pc;
        r.insn       = c ? 32'h0000_0001 : 32'h0000_0013;
        r.compressed = c;
        r.exception  = 1'b0;
        stim_q.push_back(r);
        pc = pc + (c ? 32'd2 : 32'd4);
    endtask

    task automatic cond_branch(input logic c, input logic taken, input logic exc);
        trdb_retire_t r;
        trdb_insn_t   m;
        if (c) begin
            m      = ($urandom % 2 != 0) ? MATCH_C_BEQZ : MATCH_C_BNEZ;
            r.insn = m | ($urandom & 32'h0000_1ffc);
        end else begin
            case ($urandom % 8)
                0: m = MATCH_BEQ;
                1: m = MATCH_BNE;
                2: m = MATCH_BLT;
                3: m = MATCH_BGE;
                4: m = MATCH_BLTU;
                5: m = MATCH_BGEU;
                6: m = MATCH_P_BEQIMM;
                default: m = MATCH_P_BNEIMM;
            endcase
            r.insn = m | ($urandom & 32'hffff_8f80);
        end
        r.iaddr      = pc;
        r.compressed = c;
        r.exception  = exc;
        stim_q.push_back(r);
        // forward target never equals the fall-through
        if (exc) pc = 32'h8000_0100;
        else if (taken) pc = pc + 32'd16 + 32'd2 * ($urandom % 64);
        else pc = pc + (c ? 32'd2 : 32'd4);
    endtask

    task automatic indirect_jump();
        trdb_retire_t r;
        r.iaddr      = pc;
        r.insn       = MATCH_JALR | ($urandom & 32'hffff_8f80);
        r.compressed = 1'b0;
        r.exception  = 1'b0;
        stim_q.push_back(r);
        pc = $urandom & 32'hffff_fffe;
    endtask

    // faulting alu op, continues at the trap vector
    task automatic trap_entry();
        straight_line(1'b0);
        stim_q[stim_q.size()-1].exception = 1'b1;
        pc = 32'h8000_0100;
    endtask

    task automatic random_program(input int n);
        for (int i = 0; i < n; i++) begin
            case ($urandom % 10)
                0, 1, 2, 3: straight_line(1'($urandom % 2));
                8: indirect_jump();
                9: trap_entry();
                default: cond_branch(1'($urandom % 2), 1'($urandom % 2), 1'b0);
            endcase
        end
    endtask

    // reference model, one step per tc/nc pair
    task automatic build_expected();
        logic         run;
        logic         tcb;
        logic         tcu;
        trdb_bmap_t   map;
        int           cnt;
        trdb_addr_t   last;
        trdb_retire_t tc;
        trdb_retire_t nc;
        trdb_packet_t p;
        run  = 1'b0;
        tcb  = 1'b0;
        tcu  = 1'b0;
        map  = '0;
        cnt  = 0;
        last = '0;
        exp_q.delete();
        for (int i = 1; i < stim_q.size(); i++) begin
            tc = stim_q[i-1];
            nc = stim_q[i];
            p  = '0;
            if (!run) begin
                p.format  = FMT_SYNC;
                p.address = tc.iaddr;
                last      = tc.iaddr;
                run       = 1'b1;
                exp_q.push_back(p);
            end else begin
                if (tcb) begin
                    map[cnt] = (nc.iaddr != tc.iaddr + (tc.compressed ? 32'd2 : 32'd4));
                    cnt++;
                end
                p.branch_count = trdb_bcount_t'(cnt);
                p.branch_map   = map;
                // discontinuity beats a full map
                if (tcu) begin
                    p.format  = FMT_ADDR;
                    p.address = nc.iaddr - last;
                    last      = nc.iaddr;
                    exp_q.push_back(p);
                    map = '0;
                    cnt = 0;
                end else if (cnt == `TRDB_BRANCH_MAP_LEN) begin
                    p.format = FMT_BRANCH;
                    exp_q.push_back(p);
                    map = '0;
                    cnt = 0;
                end
            end
            tcb = is_branch(nc.insn);
            tcu = ((nc.insn & MASK_JALR) == MATCH_JALR) || nc.exception;
        end
    endtask

    task automatic reset_dut();
        #2;
        arst_n_i       = 1'b0;
        retire_valid_i = 1'b0;
        retire_i       = '0;
        repeat (8) @(posedge clk_i);
        #2;
        arst_n_i   = 1'b1;
        first_seen = 1'b0;
        got_q.delete();
    endtask

    // strobes with up to max_gap idle cycles between them
    task automatic drive_stream(input int max_gap);
        int gap;
        for (int i = 0; i < stim_q.size(); i++) begin
            @(posedge clk_i);
            #2;
            retire_valid_i = 1'b1;
            retire_i       = stim_q[i];
            // sampled next edge, packet registered one edge after that
            if (i == 1) sync_cyc = cyc + 2;
            gap = (max_gap > 0) ? int'($urandom % 32'(max_gap + 1)) : 0;
            if (gap > 0) begin
                @(posedge clk_i);
                #2;
                retire_valid_i = 1'b0;
                repeat (gap - 1) @(posedge clk_i);
            end
        end
        @(posedge clk_i);
        #2;
        retire_valid_i = 1'b0;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (exp_q.size() != 0 && t < 500) begin
            @(posedge clk_i);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout while %0d expected packets never arrived", exp_q.size());
            $display("Result: FAILED");
            $finish;
        end else begin
            // a few more cycles to catch stray packets
            repeat (4) @(posedge clk_i);
        end
    endtask

    function automatic int count_format(input trdb_format_e f);
        int n;
        n = 0;
        foreach (got_q[i]) if (got_q[i].format == f) n++;
        return n;
    endfunction

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            $display("test %s: ok, %0d packets", name, got_q.size());
        end else begin
            fail_tests++;
            $display("test %s: failed", name);
        end
    endtask

    task automatic start_program();
        reset_dut();
        stim_q.delete();
        pc = 32'h1000_0000;
        straight_line(1'b0);
        straight_line(1'b1);
    endtask

    initial begin
        int e;
        void'($urandom(32'h7a96cb8f));
        arst_n_i       = 1'b0;
        retire_valid_i = 1'b0;
        retire_i       = '0;
        first_seen     = 1'b0;

        e = err_cnt;
        start_program();
        straight_line(1'b0);
        build_expected();
        drive_stream(2);
        wait_drained();
        check_field("sync packet count", 32'(count_format(FMT_SYNC)), 32'd1);
        report_test("sync", e);

        // 31 branches in a row fill the map once
        e = err_cnt;
        start_program();
        for (int k = 0; k < 31; k++) cond_branch(1'($urandom % 2), 1'($urandom % 2), 1'b0);
        straight_line(1'b0);
        straight_line(1'b0);
        build_expected();
        drive_stream(0);
        wait_drained();
        check_field("branch packet count", 32'(count_format(FMT_BRANCH)), 32'd1);
        report_test("branch_map", e);

        e = err_cnt;
        start_program();
        for (int k = 0; k < 3; k++) cond_branch(1'b0, 1'($urandom % 2), 1'b0);
        indirect_jump();
        straight_line(1'b0);
        straight_line(1'b1);
        straight_line(1'b0);
        build_expected();
        drive_stream(1);
        wait_drained();
        check_field("addr packet count", 32'(count_format(FMT_ADDR)), 32'd1);
        report_test("address", e);

        // 31st branch faults, map full on the same pair
        e = err_cnt;
        start_program();
        for (int k = 0; k < 30; k++) cond_branch(1'($urandom % 2), 1'($urandom % 2), 1'b0);
        cond_branch(1'b0, 1'b1, 1'b1);
        straight_line(1'b0);
        straight_line(1'b0);
        build_expected();
        drive_stream(0);
        wait_drained();
        check_field("addr packet count", 32'(count_format(FMT_ADDR)), 32'd1);
        check_field("branch packet count", 32'(count_format(FMT_BRANCH)), 32'd0);
        report_test("exception", e);

        // same program back to back and with gaps
        e = err_cnt;
        reset_dut();
        stim_q.delete();
        pc = 32'h2000_0000;
        random_program(200);
        build_expected();
        drive_stream(0);
        wait_drained();
        ref_q = got_q;
        reset_dut();
        build_expected();
        drive_stream(3);
        wait_drained();
        check_field("packet sequence length", 32'(got_q.size()), 32'(ref_q.size()));
        for (int i = 0; i < got_q.size() && i < ref_q.size(); i++) begin
            check_field("packet_o.format with gaps", 32'(got_q[i].format),
                        32'(ref_q[i].format));
            check_field("packet_o.branch_count with gaps", 32'(got_q[i].branch_count),
                        32'(ref_q[i].branch_count));
            check_field("packet_o.branch_map with gaps", 32'(got_q[i].branch_map),
                        32'(ref_q[i].branch_map));
            check_field("packet_o.address with gaps", got_q[i].address, ref_q[i].address);
        end
        report_test("gaps", e);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/trdb_pkg.sv
verilog/trdb_retire_pipe.sv
verilog/trdb_itype_detector.sv
verilog/trdb_addr_tracker.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_encoder.sv
tests/trdb_encoder_properties.sv
tests/tb_trdb_encoder.sv

//--- Makefile
# Verilator flow for the trace encoder testbench

VERILATOR ?= verilator
TOP       ?= tb_trdb_encoder
RTL_TOP   ?= trdb_encoder
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "Result: PASSED" $(LOG) || (echo "simulation ended early"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
